/* Bender.yml */
package:
  name: hdd_bridge

sources:
  - verilog/hdd_pkg.sv
  - verilog/hdd_cmd_if.sv
  - verilog/byte_pointer.sv
  - verilog/sector_buffer.sv
  - verilog/hdd_regs.sv
  - verilog/hdd_request_fsm.sv
  - verilog/hdd_bridge_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/hdd_bridge_tb.sv

/* bench/hdd_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hdd_bridge_tb;
	import hdd_pkg::*;

	localparam int drive_delay = 1;
	localparam int wait_limit  = 2000;  // cycles allowed for any single wait.

	logic        clk_sys;
	logic        reset;
	reg_addr_t   cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_wr;
	logic        cpu_rd;
	logic [7:0]  cpu_rdata;
	logic        cpu_wait;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout;
	logic [7:0]  sd_buff_din;
	logic        sd_buff_wr;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;

	logic [15:0] lfsr_state;
	logic [7:0]  stream_bytes [0:sector_bytes-1];  // bytes the host sent or the CPU wrote.
	logic [7:0]  captured [0:sector_bytes-1];      // bytes the host read back.
	int          check_count;
	int          fail_count;
	logic        timed_out;

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	hdd_bridge_top u_dut (.*);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois form with taps 16, 14, 13 and 11.
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [7:0] status_byte(input logic busy, mounted, protect, error);
		logic [7:0] s;
		s               = 8'h00;
		s[stat_busy]    = busy;
		s[stat_mounted] = mounted;
		s[stat_protect] = protect;
		s[stat_error]   = error;
		return s;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			fail_count++;
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk_sys);
		#drive_delay;
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s after %0d cycles", what, wait_limit);
		fail_count++;
		timed_out = 1'b1;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		while (!(sd_rd || sd_wr) && !timed_out) begin
			if (n == wait_limit) begin
				note_timeout("no host request was raised");
			end
			wait_cycle();
			n++;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (cpu_wait && !timed_out) begin
			if (n == wait_limit) begin
				note_timeout("cpu_wait never fell");
			end
			wait_cycle();
			n++;
		end
	endtask

	task automatic write_reg(input reg_addr_t a, input logic [7:0] d);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_wr    = 1'b1;
		wait_cycle();  // the DUT takes the write on this edge.
		cpu_wr    = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t a, output logic [7:0] d);
		cpu_addr = a;
		cpu_rd   = 1'b1;
		wait_cycle();
		cpu_rd   = 1'b0;
		d        = cpu_rdata;  // valid on the cycle after the strobe.
	endtask

	task automatic check_status(input string name, input logic [7:0] exp);
		logic [7:0] s;
		read_reg(reg_cmd_status, s);
		check(name, s, exp);
	endtask

	task automatic mount(input logic [63:0] size, input logic ro);
		img_size     = size;
		img_readonly = ro;
		img_mounted  = 1'b1;
		wait_cycle();
		img_mounted  = 1'b0;
	endtask

	// the host model acks after a delay and then moves one whole sector.
	task automatic host_answer(input int ack_delay);
		logic is_read;
		wait_request();
		is_read = sd_rd;
		repeat (ack_delay) wait_cycle();
		sd_ack = 1'b1;
		for (int a = 0; a < sector_bytes; a++) begin
			sd_buff_addr = 9'(a);
			if (is_read) begin
				random_byte(stream_bytes[a]);
				sd_buff_dout = stream_bytes[a];
				sd_buff_wr   = 1'b1;
				wait_cycle();
			end else begin
				wait_cycle();
				captured[a] = sd_buff_din;  // registered read of this address.
			end
		end
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
	endtask

	task automatic end_test(input string name, input int fails_before);
		$display("test %s: %0d failures", name, fail_count - fails_before);
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset_mount();
		int f0;
		f0 = fail_count;
		check_status("status", status_byte(0, 0, 0, 0));
		write_reg(reg_cmd_status, cmd_read);
		repeat (3) begin
			wait_cycle();
			check("sd_rd", sd_rd, 1'b0);
		end
		check_status("status", status_byte(0, 0, 0, 1));
		mount(64'd0, 1'b0);
		check_status("status", status_byte(0, 0, 0, 1));
		mount(64'd1048576, 1'b1);
		check_status("status", status_byte(0, 1, 1, 1));
		end_test("reset and mount", f0);
	endtask

	task automatic test_protected_write();
		int f0;
		f0 = fail_count;
		// an accepted read first clears the error left by the last test.
		write_reg(reg_cmd_status, cmd_read);
		host_answer(0);
		wait_idle();
		check_status("status", status_byte(0, 1, 1, 0));
		write_reg(reg_cmd_status, cmd_write);
		repeat (3) begin
			wait_cycle();
			check("sd_wr", sd_wr, 1'b0);
		end
		check_status("status", status_byte(0, 1, 1, 1));
		write_reg(reg_cmd_status, cmd_read);
		host_answer(0);
		wait_idle();
		check_status("status", status_byte(0, 1, 1, 0));
		end_test("protected write", f0);
	endtask

	task automatic test_sector_read();
		int         f0;
		logic [7:0] d;
		f0 = fail_count;
		write_reg(reg_sector_lo, 8'h34);
		write_reg(reg_sector_hi, 8'h12);
		write_reg(reg_cmd_status, cmd_read);
		check("cpu_wait", cpu_wait, 1'b0);
		wait_cycle();
		check("cpu_wait", cpu_wait, 1'b1);
		check("sd_rd", sd_rd, 1'b1);
		check("sd_wr", sd_wr, 1'b0);
		check("sd_lba", sd_lba, 32'h0000_1234);
		host_answer(0);
		wait_idle();
		for (int i = 0; i < sector_bytes; i++) begin
			read_reg(reg_data, d);
			check("cpu_rdata", d, stream_bytes[i]);
		end
		end_test("sector read", f0);
	endtask

	task automatic test_sector_write();
		int f0;
		f0 = fail_count;
		mount(64'd1048576, 1'b0);
		// the pointer is back at 0 after the 512 reads of the last test.
		for (int i = 0; i < sector_bytes; i++) begin
			random_byte(stream_bytes[i]);
			write_reg(reg_data, stream_bytes[i]);
		end
		write_reg(reg_cmd_status, cmd_write);
		host_answer(2);
		wait_idle();
		for (int i = 0; i < sector_bytes; i++) begin
			check("sd_buff_din", captured[i], stream_bytes[i]);
		end
		check_status("status", status_byte(0, 1, 0, 0));
		end_test("sector write", f0);
	endtask

	task automatic test_back_pressure();
		int f0;
		f0 = fail_count;
		mount(64'd1048576, 1'b1);
		write_reg(reg_cmd_status, cmd_read);
		wait_request();
		write_reg(reg_cmd_status, cmd_write);  // would be rejected if it were not ignored.
		repeat (8) begin
			wait_cycle();
			check("cpu_wait", cpu_wait, 1'b1);
			check("sd_rd", sd_rd, 1'b1);
			check("sd_wr", sd_wr, 1'b0);
		end
		check_status("status", status_byte(1, 1, 1, 0));
		sd_ack = 1'b1;
		repeat (10) begin
			wait_cycle();
			check("cpu_wait", cpu_wait, 1'b1);
			check("sd_rd", sd_rd, 1'b0);
		end
		sd_ack = 1'b0;
		wait_idle();
		check_status("status", status_byte(0, 1, 1, 0));
		check("sd_rd", sd_rd, 1'b0);
		check("sd_wr", sd_wr, 1'b0);
		end_test("back-pressure and busy", f0);
	endtask

	initial begin
		cpu_addr     = reg_sector_lo;
		cpu_wdata    = 8'h00;
		cpu_wr       = 1'b0;
		cpu_rd       = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = 8'h00;
		sd_buff_wr   = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'd0;
		lfsr_state   = 16'd26;
		check_count  = 0;
		fail_count   = 0;
		timed_out    = 1'b0;
		wait_cycle();
		for (int n = 0; reset !== 1'b0 && !timed_out; n++) begin
			if (n == wait_limit) begin
				note_timeout("reset never released");
			end
			wait_cycle();
		end
		if (!timed_out) test_reset_mount();
		if (!timed_out) test_protected_write();
		if (!timed_out) test_sector_read();
		if (!timed_out) test_sector_write();
		if (!timed_out) test_back_pressure();
		$display("checks: %0d, failures: %0d", check_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;  // 100 ns period.
	end

	// reset covers the first three rising edges.
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/hdd_pkg.sv
verilog/hdd_cmd_if.sv
verilog/byte_pointer.sv
verilog/sector_buffer.sv
verilog/hdd_regs.sv
verilog/hdd_request_fsm.sv
verilog/hdd_bridge_top.sv
bench/tb_clock.sv
bench/hdd_bridge_tb.sv

/* verilog/byte_pointer.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_pointer (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               clear,
	input  logic                               advance,
	output logic [hdd_pkg::buf_addr_width-1:0] ptr
);

	// --------------------------------------------------
	// CPU side buffer address
	// --------------------------------------------------

	// clear wins over advance, so a transfer always starts at byte 0.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ptr <= '0;
		end else if (clear) begin
			ptr <= '0;
		end else if (advance) begin
			ptr <= ptr + 1'b1;  // wraps from 511 back to 0.
		end
	end

endmodule

`default_nettype wire

/* verilog/hdd_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hdd_bridge_top (
	input  logic                               clk_sys,
	input  logic                               reset,
	// CPU register window.
	input  hdd_pkg::reg_addr_t                 cpu_addr,
	input  logic [7:0]                         cpu_wdata,
	input  logic                               cpu_wr,
	input  logic                               cpu_rd,
	output logic [7:0]                         cpu_rdata,
	output logic                               cpu_wait,
	// host block interface.
	output logic [31:0]                        sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	input  logic                               sd_ack,
	input  logic [hdd_pkg::buf_addr_width-1:0] sd_buff_addr,
	input  logic [7:0]                         sd_buff_dout,
	output logic [7:0]                         sd_buff_din,
	input  logic                               sd_buff_wr,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic [63:0]                        img_size
);
	import hdd_pkg::*;

	logic [buf_addr_width-1:0] cpu_ptr;
	logic [7:0]                buf_cpu_rdata;
	logic                      data_access;
	logic                      ptr_clear;
	logic                      host_we;
	logic                      cpu_we;

	hdd_cmd_if cmd_bus ();

	assign host_we  = sd_buff_wr & sd_ack;  // stray writes outside a transfer are dropped.
	assign cpu_we   = data_access & cpu_wr;
	assign cpu_wait = cmd_bus.busy;

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	hdd_regs u_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_wr       (cpu_wr),
		.cpu_rd       (cpu_rd),
		.cpu_rdata    (cpu_rdata),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.buf_rdata    (buf_cpu_rdata),
		.data_access  (data_access),
		.cmd          (cmd_bus)
	);

	hdd_request_fsm u_fsm (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cmd       (cmd_bus),
		.sd_lba    (sd_lba),
		.sd_rd     (sd_rd),
		.sd_wr     (sd_wr),
		.sd_ack    (sd_ack),
		.ptr_clear (ptr_clear)
	);

	// --------------------------------------------------
	// data path
	// --------------------------------------------------
	byte_pointer u_ptr (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (ptr_clear),
		.advance (data_access),
		.ptr     (cpu_ptr)
	);

	sector_buffer u_buf (
		.clk_sys    (clk_sys),
		.host_addr  (sd_buff_addr),
		.host_wdata (sd_buff_dout),
		.host_we    (host_we),
		.host_rdata (sd_buff_din),
		.cpu_addr   (cpu_ptr),
		.cpu_wdata  (cpu_wdata),
		.cpu_we     (cpu_we),
		.cpu_rdata  (buf_cpu_rdata)
	);

endmodule

`default_nettype wire

/* verilog/hdd_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// command path from the register window to the request FSM.
interface hdd_cmd_if;
	import hdd_pkg::*;

	logic [sector_width-1:0] sector;       // sector number for the next request.
	logic                    start_read;   // one-cycle pulse per accepted read.
	logic                    start_write;  // one-cycle pulse per accepted write.
	logic                    busy;         // high from request to ack release.

	modport regs_side (
		output sector,
		output start_read,
		output start_write,
		input  busy
	);

	modport fsm_side (
		input  sector,
		input  start_read,
		input  start_write,
		output busy
	);

endinterface

`default_nettype wire

/* verilog/hdd_pkg.sv */
`default_nettype none

package hdd_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int sector_bytes   = 512;  // bytes moved per host block request.
	localparam int buf_addr_width = 9;    // addresses one sector buffer.
	localparam int sector_width   = 16;   // the host lba is this, zero-extended.

	// --------------------------------------------------
	// status byte bit positions
	// --------------------------------------------------
	localparam int stat_busy    = 0;
	localparam int stat_mounted = 1;
	localparam int stat_protect = 2;
	localparam int stat_error   = 3;  // set by the last rejected command.

	typedef enum logic [1:0] {
		reg_sector_lo  = 2'd0,
		reg_sector_hi  = 2'd1,
		reg_cmd_status = 2'd2,  // write gives a command, read gives status.
		reg_data       = 2'd3   // auto-incrementing buffer port.
	} reg_addr_t;

	typedef enum logic [7:0] {
		cmd_none  = 8'd0,
		cmd_read  = 8'd1,
		cmd_write = 8'd2
	} cmd_t;

	typedef enum logic [1:0] {
		st_idle,
		st_request,  // sd_rd or sd_wr held until the host acks.
		st_release   // waiting for the host to drop sd_ack.
	} req_state_t;

endpackage

`default_nettype wire

/* verilog/hdd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hdd_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  hdd_pkg::reg_addr_t cpu_addr,
	input  logic [7:0]         cpu_wdata,
	input  logic               cpu_wr,
	input  logic               cpu_rd,
	output logic [7:0]         cpu_rdata,
	input  logic               img_mounted,
	input  logic               img_readonly,
	input  logic [63:0]        img_size,
	input  logic [7:0]         buf_rdata,
	output logic               data_access,
	hdd_cmd_if.regs_side       cmd
);
	import hdd_pkg::*;

	logic [sector_width-1:0] sector;
	logic                    mounted;
	logic                    protect;
	logic                    error;
	logic                    busy_any;
	logic                    cmd_write_en;
	cmd_t                    cmd_code;
	logic [7:0]              status;
	logic [7:0]              rd_hold;
	logic                    rd_from_buf;

	// a start pulse still in flight counts as busy, the FSM only raises busy a cycle later.
	assign busy_any     = cmd.busy | cmd.start_read | cmd.start_write;
	assign cmd_write_en = cpu_wr && (cpu_addr == reg_cmd_status);
	assign cmd_code     = cmd_t'(cpu_wdata);
	assign data_access  = (cpu_wr || cpu_rd) && (cpu_addr == reg_data);  // steps the pointer.
	assign cmd.sector   = sector;

	always_comb begin
		status               = 8'h00;
		status[stat_busy]    = busy_any;
		status[stat_mounted] = mounted;
		status[stat_protect] = protect;
		status[stat_error]   = error;
	end

	// --------------------------------------------------
	// sector number and image state
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sector  <= '0;
			mounted <= 1'b0;
			protect <= 1'b0;
		end else begin
			if (cpu_wr && (cpu_addr == reg_sector_lo)) begin
				sector[7:0] <= cpu_wdata;
			end
			if (cpu_wr && (cpu_addr == reg_sector_hi)) begin
				sector[15:8] <= cpu_wdata;
			end
			if (img_mounted) begin
				mounted <= (img_size != 64'd0);  // an empty image counts as no disk.
				protect <= img_readonly;
			end
		end
	end

	// --------------------------------------------------
	// command check
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			error           <= 1'b0;
			cmd.start_read  <= 1'b0;
			cmd.start_write <= 1'b0;
		end else begin
			cmd.start_read  <= 1'b0;
			cmd.start_write <= 1'b0;
			if (cmd_write_en && !busy_any) begin  // writes while busy are dropped silently.
				case (cmd_code)
					cmd_read: begin
						cmd.start_read <= mounted;
						error          <= !mounted;
					end
					cmd_write: begin
						cmd.start_write <= mounted && !protect;
						error           <= !(mounted && !protect);
					end
					default: begin
						error <= error;  // cmd_none and unknown codes change nothing.
					end
				endcase
			end
		end
	end

	// read data shows up on the cycle after cpu_rd.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_from_buf <= 1'b0;
		end else if (cpu_rd) begin
			rd_from_buf <= (cpu_addr == reg_data);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_rd) begin
			case (cpu_addr)
				reg_sector_lo:  rd_hold <= sector[7:0];
				reg_sector_hi:  rd_hold <= sector[15:8];
				reg_cmd_status: rd_hold <= status;
				default:        rd_hold <= 8'h00;
			endcase
		end
	end

	assign cpu_rdata = rd_from_buf ? buf_rdata : rd_hold;  // buffer port is already registered.

	// the request FSM never sees a new start while a transfer is running.
	a_start_only_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(cmd.start_read || cmd.start_write) |-> !cmd.busy);

endmodule

`default_nettype wire

/* verilog/hdd_request_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module hdd_request_fsm (
	input  logic        clk_sys,
	input  logic        reset,
	hdd_cmd_if.fsm_side cmd,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	output logic        ptr_clear
);
	import hdd_pkg::*;

	req_state_t state;
	logic       start;

	assign start     = cmd.start_read | cmd.start_write;
	assign ptr_clear = start;  // the CPU pointer rewinds for every transfer.

	// --------------------------------------------------
	// host request sequencing
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= st_idle;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			cmd.busy <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						sd_rd    <= cmd.start_read;
						sd_wr    <= cmd.start_write;
						cmd.busy <= 1'b1;
						state    <= st_request;
					end
				end

				st_request: begin
					// the host may take any time to pick the request up.
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= st_release;
					end
				end

				st_release: begin
					// sd_ack stays up for the whole byte stream.
					if (!sd_ack) begin
						cmd.busy <= 1'b0;
						state    <= st_idle;
					end
				end

				default: begin
					sd_rd    <= 1'b0;
					sd_wr    <= 1'b0;
					cmd.busy <= 1'b0;
					state    <= st_idle;
				end
			endcase
		end
	end

	// the sector is frozen at start so the CPU may rewrite it during the transfer.
	always_ff @(posedge clk_sys) begin
		if (start) begin
			sd_lba <= {{(32 - sector_width){1'b0}}, cmd.sector};
		end
	end

	// one request type at a time towards the host.
	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

endmodule

`default_nettype wire

/* verilog/sector_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
	input  logic                               clk_sys,
	input  logic [hdd_pkg::buf_addr_width-1:0] host_addr,
	input  logic [7:0]                         host_wdata,
	input  logic                               host_we,
	output logic [7:0]                         host_rdata,
	input  logic [hdd_pkg::buf_addr_width-1:0] cpu_addr,
	input  logic [7:0]                         cpu_wdata,
	input  logic                               cpu_we,
	output logic [7:0]                         cpu_rdata
);
	import hdd_pkg::*;

	logic [7:0] mem [0:sector_bytes-1];

	// --------------------------------------------------
	// host port
	// --------------------------------------------------
	always @(posedge clk_sys) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata;
		end
		host_rdata <= mem[host_addr];  // old data on a same-cycle write.
	end

	// --------------------------------------------------
	// CPU port
	// --------------------------------------------------
	// Both ports never write during the same transfer, the CPU is held off by cpu_wait.
	always @(posedge clk_sys) begin
		if (cpu_we) begin
			mem[cpu_addr] <= cpu_wdata;
		end
		cpu_rdata <= mem[cpu_addr];
	end

endmodule

`default_nettype wire
